//--- vlog.f
+incdir+source
source/gpu_pkg.sv
source/gpu_cmd_fifo.sv
source/gpu_controller.sv
source/gpu_line_engine.sv
source/gpu_fill_engine.sv
source/gpu_arc_engine.sv
source/gpu_pixel_out.sv
source/gpu_top.sv
dv/gpu_assert.sv
dv/gpu_tb.sv

//--- Bender.yml
package:
  name: gpu_raster

sources:
  - include_dirs:
      - source
    files:
      - source/gpu_pkg.sv
      - source/gpu_cmd_fifo.sv
      - source/gpu_controller.sv
      - source/gpu_line_engine.sv
      - source/gpu_fill_engine.sv
      - source/gpu_arc_engine.sv
      - source/gpu_pixel_out.sv
      - source/gpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/gpu_assert.sv
      - dv/gpu_tb.sv

//--- dv/gpu_tb.sv
`include "gpu_cfg.svh"

module gpu_tb;

  localparam int XW       = `GPU_WIDTH_BITS;
  localparam int YW       = `GPU_HEIGHT_BITS;
  localparam int XMAX     = (1 << XW) - 1;
  localparam int YMAX     = (1 << YW) - 1;
  localparam int CB       = $bits(gpu_pkg::color_t);
  localparam int NUM_CMDS = 30;
  localparam int MAX_PIX  = XMAX + 1;   // longest line, fills stay at 16x16

  logic             clk;
  logic             n_rst;
  gpu_pkg::cmd_t    cmd;
  logic             cmd_valid;
  logic             cmd_full;
  gpu_pkg::pix_wr_t pix;
  logic             pix_valid;
  logic             flush;

  gpu_top DUT (
    .clk(clk), .n_rst(n_rst), .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_full_o(cmd_full),
    .pix_o(pix), .pix_valid_o(pix_valid), .flush_o(flush)
  );

  function automatic gpu_pkg::cmd_t line_cmd();
    gpu_pkg::cmd_t c;
    c = '0;
    c.op = gpu_pkg::OP_LINE;
    c.coord.corners.x1 = XW'($urandom_range(0, XMAX));
    c.coord.corners.y1 = YW'($urandom_range(0, YMAX));
    c.coord.corners.x2 = XW'($urandom_range(0, XMAX));
    c.coord.corners.y2 = YW'($urandom_range(0, YMAX));
    c.color = CB'($urandom);
    return c;
  endfunction

  function automatic gpu_pkg::cmd_t fill_cmd();
    gpu_pkg::cmd_t c;
    int x;
    int y;
    int w;
    int h;
    c = '0;
    c.op = gpu_pkg::OP_FILL;
    x = $urandom_range(0, XMAX - 15);
    y = $urandom_range(0, YMAX - 15);
    w = $urandom_range(0, 15);
    h = $urandom_range(0, 15);
    c.coord.corners.x1 = XW'(x);
    c.coord.corners.x2 = XW'(x + w);
    c.coord.corners.y1 = YW'(y + h);   // y corners given high first
    c.coord.corners.y2 = YW'(y);
    if ($urandom_range(0, 1) == 1)
    begin
      c.coord.corners.x1 = XW'(x + w);
      c.coord.corners.x2 = XW'(x);
    end
    c.color = CB'($urandom);
    return c;
  endfunction

  // center kept far enough from the edges that no octant wraps
  function automatic gpu_pkg::cmd_t arc_cmd(input logic [2:0] oct);
    gpu_pkg::cmd_t c;
    c = '0;
    c.op = gpu_pkg::OP_ARC;
    c.coord.arc.cx  = XW'($urandom_range(XMAX / 4, XMAX - XMAX / 4));
    c.coord.arc.cy  = YW'($urandom_range(YMAX / 4, YMAX - YMAX / 4));
    c.coord.arc.rad = XW'($urandom_range(1, XMAX / 4 - 4));
    c.coord.arc.oct = oct;
    c.color = CB'($urandom);
    return c;
  endfunction

  function automatic gpu_pkg::cmd_t ctrl_cmd(gpu_pkg::opcode_e op);
    gpu_pkg::cmd_t c;
    c = line_cmd();   // random payload that must be ignored
    c.op = op;
    return c;
  endfunction

  function automatic gpu_pkg::cmd_t mixed_cmd(int i);
    case (i % 5)
      0: return line_cmd();
      1: return fill_cmd();
      2: return arc_cmd(3'($urandom_range(0, 7)));
      3: return ctrl_cmd(gpu_pkg::OP_FLUSH);
      default: return ctrl_cmd(gpu_pkg::opcode_e'(4'hf));
    endcase
  endfunction

  task automatic send_cmd(input gpu_pkg::cmd_t c);
    @(posedge clk);
    #10;
    cmd       = c;
    cmd_valid = 1'b1;
  endtask

  task automatic drop_valid();
    @(posedge clk);
    #10;
    cmd_valid = 1'b0;
  endtask

  // queue drained and outputs quiet for a few cycles
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 4)
    begin
      @(negedge clk);
      if (DUT.empty && !pix_valid && !flush)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    #(((NUM_CMDS * (MAX_PIX + 10)) + 20) * 100);
    $display("run timed out before all commands were drawn");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    void'($urandom(17));
    n_rst     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    n_rst = 1'b1;
    repeat (4) @(posedge clk);   // outputs must stay quiet here

    for (int i = 0; i < 4; i++)
    begin
      send_cmd(line_cmd());
      drop_valid();
      wait_idle();
    end
    for (int i = 0; i < 2; i++)
    begin
      send_cmd(fill_cmd());
      drop_valid();
      wait_idle();
    end
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(arc_cmd(3'(i)));
      drop_valid();
      wait_idle();
    end
    send_cmd(ctrl_cmd(gpu_pkg::OP_FLUSH));
    drop_valid();
    wait_idle();
    send_cmd(ctrl_cmd(gpu_pkg::opcode_e'(4'h0)));
    drop_valid();
    wait_idle();

    // back to back, overruns the queue
    for (int i = 0; i < 14; i++)
      send_cmd(mixed_cmd(i));
    drop_valid();
    wait_idle();

    $display("assertion errors: %0d", DUT.u_assert.errors);
    if (DUT.u_assert.errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- dv/gpu_assert.sv
`include "gpu_cfg.svh"

module gpu_assert
(
  input logic             clk,
  input logic             n_rst,
  input gpu_pkg::cmd_t    cmd_i,
  input logic             cmd_valid_i,
  input logic             cmd_full_i,
  input gpu_pkg::cmd_t    head_i,
  input logic             empty_i,
  input logic             pop_i,
  input logic             line_start_i,
  input logic             fill_start_i,
  input logic             arc_start_i,
  input gpu_pkg::pix_wr_t pix_i,
  input logic             pix_valid_i,
  input logic             flush_i
);

  int errors = 0;

  gpu_pkg::cmd_t     cur;         // draw whose writes are coming out
  gpu_pkg::cmd_t     ref_q [16];  // accepted commands in push order
  gpu_pkg::pixel_t   last;
  gpu_pkg::corners_t cc;
  gpu_pkg::arc_t     ca;
  logic [3:0] wr_idx;
  logic [3:0] rd_idx;
  logic [3:0] occ;   // commands accepted and not yet retired
  logic start;
  logic in_draw;
  logic seen_cmd;
  int cnt;

  assign start = line_start_i || fill_start_i || arc_start_i;
  assign cc    = cur.coord.corners;
  assign ca    = cur.coord.arc;
  assign occ   = wr_idx - rd_idx;

  function automatic logic is_draw(gpu_pkg::opcode_e op);
    return (op == gpu_pkg::OP_LINE) || (op == gpu_pkg::OP_FILL) || (op == gpu_pkg::OP_ARC);
  endfunction

  function automatic int span(int a, int b);
    return (a > b) ? a - b : b - a;
  endfunction

  function automatic int line_len(gpu_pkg::corners_t c);
    int dx;
    int dy;
    dx = span(c.x1, c.x2);
    dy = span(c.y1, c.y2);
    return ((dx > dy) ? dx : dy) + 1;
  endfunction

  function automatic int fill_area(gpu_pkg::corners_t c);
    return (span(c.x1, c.x2) + 1) * (span(c.y1, c.y2) + 1);
  endfunction

  function automatic logic in_rect(gpu_pkg::corners_t c, gpu_pkg::pixel_t p);
    logic x_ok;
    logic y_ok;
    x_ok = (p.x >= ((c.x1 < c.x2) ? c.x1 : c.x2)) && (p.x <= ((c.x1 < c.x2) ? c.x2 : c.x1));
    y_ok = (p.y >= ((c.y1 < c.y2) ? c.y1 : c.y2)) && (p.y <= ((c.y1 < c.y2) ? c.y2 : c.y1));
    return x_ok && y_ok;
  endfunction

  // octants 0 and 7 start on +x, 1 and 2 on +y, 3 and 4 on -x, 5 and 6 on -y
  function automatic gpu_pkg::pixel_t arc_first(gpu_pkg::arc_t a);
    gpu_pkg::pixel_t p;
    p.x = a.cx;
    p.y = a.cy;
    case (((int'(a.oct) + 1) / 2) % 4)
      0: p.x = a.cx + a.rad;
      1: p.y = a.cy + a.rad;
      2: p.x = a.cx - a.rad;
      default: p.y = a.cy - a.rad;
    endcase
    return p;
  endfunction

  function automatic int arc_err(gpu_pkg::arc_t a, gpu_pkg::pixel_t p);
    int dx;
    int dy;
    int e;
    dx = int'(p.x) - int'(a.cx);
    dy = int'(p.y) - int'(a.cy);
    e  = dx * dx + dy * dy - int'(a.rad) * int'(a.rad);
    return (e < 0) ? -e : e;
  endfunction

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      cur      <= '0;
      last     <= '0;
      cnt      <= 0;
      in_draw  <= 1'b0;
      seen_cmd <= 1'b0;
      wr_idx   <= '0;
      rd_idx   <= '0;
    end
    else
    begin
      if (start)
      begin
        cur <= head_i;
        cnt <= 0;
      end
      else if (pix_valid_i)
        cnt <= cnt + 1;
      if (pix_valid_i)
        last <= pix_i.pix;
      if (start)
        in_draw <= 1'b1;
      else if (pop_i)
        in_draw <= 1'b0;
      if (cmd_valid_i)
        seen_cmd <= 1'b1;
      if (cmd_valid_i && !cmd_full_i)
        wr_idx <= wr_idx + 1'b1;
      if (pop_i)
        rd_idx <= rd_idx + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid_i && !cmd_full_i)
      ref_q[wr_idx] <= cmd_i;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    !seen_cmd |-> !pix_valid_i && !flush_i)
  else
  begin
    $error("reset: a write or flush came out before any command");
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    cmd_valid_i && empty_i && is_draw(cmd_i.op)
      |-> ##1 !pix_valid_i ##1 !pix_valid_i ##1 !pix_valid_i ##1 pix_valid_i)
  else
  begin
    $error("latency: first write did not come four cycles after the command strobe");
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pop_i |-> head_i == ref_q[rd_idx])
  else
  begin
    $error("order: expected %h, actual %h", $sampled(ref_q[rd_idx]), $sampled(head_i));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    cmd_full_i == (occ == `GPU_FIFO_DEPTH))
  else
  begin
    $error("full: expected %0b, actual %0b", $sampled(occ) == `GPU_FIFO_DEPTH,
           $sampled(cmd_full_i));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i |-> $past(in_draw) && is_draw(cur.op))
  else
  begin
    $error("stray: a write came out while no draw command was running");
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i |-> pix_i.color == cur.color)
  else
  begin
    $error("colour: expected %h, actual %h", $sampled(cur.color), $sampled(pix_i.color));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i && cnt == 0 && cur.op == gpu_pkg::OP_LINE
      |-> pix_i.pix.x == cc.x1 && pix_i.pix.y == cc.y1)
  else
  begin
    $error("line_first: expected (%0d,%0d), actual (%0d,%0d)", $sampled(cc.x1),
           $sampled(cc.y1), $sampled(pix_i.pix.x), $sampled(pix_i.pix.y));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    $fell(pix_valid_i) && cur.op == gpu_pkg::OP_LINE |-> last.x == cc.x2 && last.y == cc.y2)
  else
  begin
    $error("line_last: expected (%0d,%0d), actual (%0d,%0d)", $sampled(cc.x2),
           $sampled(cc.y2), $sampled(last.x), $sampled(last.y));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    $fell(pix_valid_i) && cur.op == gpu_pkg::OP_LINE |-> cnt == line_len(cc))
  else
  begin
    $error("line_count: expected %0d, actual %0d", line_len($sampled(cc)), $sampled(cnt));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i && cur.op == gpu_pkg::OP_FILL |-> in_rect(cc, pix_i.pix))
  else
  begin
    $error("fill_inside: expected a pixel inside %h, actual %h", $sampled(cc),
           $sampled(pix_i.pix));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i && cnt != 0 && cur.op == gpu_pkg::OP_FILL |-> pix_i.pix != last)
  else
  begin
    $error("fill_repeat: pixel %h was written twice in a row", $sampled(last));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    $fell(pix_valid_i) && cur.op == gpu_pkg::OP_FILL |-> cnt == fill_area(cc))
  else
  begin
    $error("fill_count: expected %0d, actual %0d", fill_area($sampled(cc)), $sampled(cnt));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i && cnt == 0 && cur.op == gpu_pkg::OP_ARC |-> pix_i.pix == arc_first(ca))
  else
  begin
    $error("arc_first: octant %0d expected %h, actual %h", $sampled(ca.oct),
           arc_first($sampled(ca)), $sampled(pix_i.pix));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pix_valid_i && cur.op == gpu_pkg::OP_ARC |-> arc_err(ca, pix_i.pix) <= int'(ca.rad))
  else
  begin
    $error("arc_bound: expected error up to %0d, actual %0d", $sampled(ca.rad),
           arc_err($sampled(ca), $sampled(pix_i.pix)));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    flush_i |-> pop_i && ref_q[rd_idx].op == gpu_pkg::OP_FLUSH && !pix_valid_i)
  else
  begin
    $error("flush: strobe came without a flush command at the queue head");
    errors++;
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    pop_i && ref_q[rd_idx].op == gpu_pkg::OP_FLUSH |-> flush_i)
  else
  begin
    $error("flush: a flush command left the queue without a flush strobe");
    errors++;
  end

endmodule

bind gpu_top gpu_assert u_assert (
  .clk(clk), .n_rst(n_rst), .cmd_i(cmd_i), .cmd_valid_i(cmd_valid_i),
  .cmd_full_i(cmd_full_o), .head_i(head), .empty_i(empty), .pop_i(pop),
  .line_start_i(line_start), .fill_start_i(fill_start), .arc_start_i(arc_start),
  .pix_i(pix_o), .pix_valid_i(pix_valid_o), .flush_i(flush_o)
);

//--- source/gpu_top.sv
module gpu_top
(
  input  logic             clk,
  input  logic             n_rst,
  input  gpu_pkg::cmd_t    cmd_i,
  input  logic             cmd_valid_i,
  output logic             cmd_full_o,
  output gpu_pkg::pix_wr_t pix_o,
  output logic             pix_valid_o,
  output logic             flush_o
);

  gpu_pkg::cmd_t     head;
  gpu_pkg::corners_t corners;
  gpu_pkg::arc_t     arc;
  gpu_pkg::color_t   color;
  gpu_pkg::pixel_t   line_pix;
  gpu_pkg::pixel_t   fill_pix;
  gpu_pkg::pixel_t   arc_pix;
  logic empty;
  logic pop;
  logic line_start;
  logic fill_start;
  logic arc_start;
  logic line_valid;
  logic fill_valid;
  logic arc_valid;
  logic line_done;
  logic fill_done;
  logic arc_done;

  gpu_cmd_fifo u_fifo (
    .clk(clk), .n_rst(n_rst), .push_i(cmd_valid_i), .data_i(cmd_i), .pop_i(pop),
    .head_o(head), .empty_o(empty), .full_o(cmd_full_o)
  );

  gpu_controller u_ctrl (
    .clk(clk), .n_rst(n_rst), .cmd_i(head), .empty_i(empty), .pop_o(pop),
    .line_start_o(line_start), .fill_start_o(fill_start), .arc_start_o(arc_start),
    .corners_o(corners), .arc_o(arc), .line_done_i(line_done), .fill_done_i(fill_done),
    .arc_done_i(arc_done), .color_o(color), .flush_o(flush_o)
  );

  gpu_line_engine u_line (
    .clk(clk), .n_rst(n_rst), .start_i(line_start), .corners_i(corners),
    .pix_o(line_pix), .valid_o(line_valid), .done_o(line_done)
  );

  gpu_fill_engine u_fill (
    .clk(clk), .n_rst(n_rst), .start_i(fill_start), .corners_i(corners),
    .pix_o(fill_pix), .valid_o(fill_valid), .done_o(fill_done)
  );

  gpu_arc_engine u_arc (
    .clk(clk), .n_rst(n_rst), .start_i(arc_start), .arc_i(arc),
    .pix_o(arc_pix), .valid_o(arc_valid), .done_o(arc_done)
  );

  gpu_pixel_out u_pix (
    .clk(clk), .n_rst(n_rst),
    .line_pix_i(line_pix), .line_valid_i(line_valid),
    .fill_pix_i(fill_pix), .fill_valid_i(fill_valid),
    .arc_pix_i(arc_pix), .arc_valid_i(arc_valid),
    .color_i(color), .pix_o(pix_o), .pix_valid_o(pix_valid_o)
  );

endmodule

//--- source/gpu_pixel_out.sv
module gpu_pixel_out
(
  input  logic             clk,
  input  logic             n_rst,
  input  gpu_pkg::pixel_t  line_pix_i,
  input  logic             line_valid_i,
  input  gpu_pkg::pixel_t  fill_pix_i,
  input  logic             fill_valid_i,
  input  gpu_pkg::pixel_t  arc_pix_i,
  input  logic             arc_valid_i,
  input  gpu_pkg::color_t  color_i,
  output gpu_pkg::pix_wr_t pix_o,
  output logic             pix_valid_o
);

  gpu_pkg::pixel_t sel_pix;
  logic sel_valid;

  assign sel_valid = line_valid_i || fill_valid_i || arc_valid_i;

  // only one engine runs at a time
  always_comb
  begin
    if (line_valid_i)
      sel_pix = line_pix_i;
    else if (fill_valid_i)
      sel_pix = fill_pix_i;
    else
      sel_pix = arc_pix_i;
  end

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
      pix_valid_o <= 1'b0;
    else
      pix_valid_o <= sel_valid;
  end

  always_ff @(posedge clk)
  begin
    if (sel_valid)
    begin
      pix_o.pix   <= sel_pix;
      pix_o.color <= color_i;
    end
  end

endmodule

//--- source/gpu_arc_engine.sv
`include "gpu_cfg.svh"

module gpu_arc_engine
(
  input  logic            clk,
  input  logic            n_rst,
  input  logic            start_i,
  input  gpu_pkg::arc_t   arc_i,
  output gpu_pkg::pixel_t pix_o,
  output logic            valid_o,
  output logic            done_o
);

  localparam int W  = `GPU_WIDTH_BITS;
  localparam int H  = `GPU_HEIGHT_BITS;
  localparam int DW = W + 3;

  logic busy;
  logic [W-1:0] ax;   // canonical x, counts down from rad
  logic [W-1:0] ay;   // canonical y, counts up from zero
  logic [W-1:0] ax_n;
  logic [W-1:0] ay_n;
  logic [W-1:0] hx;
  logic [W-1:0] hy;
  logic [W-1:0] cx;
  logic [H-1:0] cy;
  logic signed [DW-1:0] d;
  logic signed [DW-1:0] d_inc;
  logic swap;
  logic neg_x;
  logic neg_y;

  assign ay_n  = ay + 1'b1;
  assign ax_n  = d[DW-1] ? ax : ax - 1'b1;
  assign d_inc = d[DW-1] ? (DW'(ay_n) <<< 1) + DW'(1)
                         : ((DW'(ay_n) - DW'(ax_n)) <<< 1) + DW'(1);

  // fold the canonical octant into the selected one
  assign hx      = swap ? ay : ax;
  assign hy      = swap ? ax : ay;
  assign pix_o.x = neg_x ? cx - hx : cx + hx;
  assign pix_o.y = neg_y ? cy - H'(hy) : cy + H'(hy);
  assign valid_o = busy;
  assign done_o  = busy && ((ay >= ax) || (ay_n > ax_n));

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
      busy <= 1'b0;
    else if (start_i)
      busy <= 1'b1;
    else if (done_o)
      busy <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      ax    <= arc_i.rad;
      ay    <= '0;
      d     <= DW'(1) - DW'(arc_i.rad);
      cx    <= arc_i.cx;
      cy    <= arc_i.cy;
      swap  <= arc_i.oct[0] ^ arc_i.oct[1];
      neg_x <= arc_i.oct[1] ^ arc_i.oct[2];
      neg_y <= arc_i.oct[2];
    end
    else if (busy && !done_o)
    begin
      ax <= ax_n;
      ay <= ay_n;
      d  <= d + d_inc;
    end
  end

endmodule

//--- source/gpu_fill_engine.sv
`include "gpu_cfg.svh"

module gpu_fill_engine
(
  input  logic              clk,
  input  logic              n_rst,
  input  logic              start_i,
  input  gpu_pkg::corners_t corners_i,
  output gpu_pkg::pixel_t   pix_o,
  output logic              valid_o,
  output logic              done_o
);

  logic busy;
  logic [`GPU_WIDTH_BITS-1:0]  x;
  logic [`GPU_WIDTH_BITS-1:0]  x_lo;
  logic [`GPU_WIDTH_BITS-1:0]  x_hi;
  logic [`GPU_HEIGHT_BITS-1:0] y;
  logic [`GPU_HEIGHT_BITS-1:0] y_hi;
  logic row_end;

  assign row_end = (x == x_hi);
  assign pix_o.x = x;
  assign pix_o.y = y;
  assign valid_o = busy;
  assign done_o  = busy && row_end && (y == y_hi);   // opposite corner

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
      busy <= 1'b0;
    else if (start_i)
      busy <= 1'b1;
    else if (done_o)
      busy <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      // order the corners so the scan always counts up
      x_lo <= (corners_i.x1 < corners_i.x2) ? corners_i.x1 : corners_i.x2;
      x_hi <= (corners_i.x1 < corners_i.x2) ? corners_i.x2 : corners_i.x1;
      y_hi <= (corners_i.y1 < corners_i.y2) ? corners_i.y2 : corners_i.y1;
      x    <= (corners_i.x1 < corners_i.x2) ? corners_i.x1 : corners_i.x2;
      y    <= (corners_i.y1 < corners_i.y2) ? corners_i.y1 : corners_i.y2;
    end
    else if (busy)
    begin
      if (row_end)
      begin
        x <= x_lo;
        y <= y + 1'b1;
      end
      else
        x <= x + 1'b1;
    end
  end

endmodule

//--- source/gpu_line_engine.sv
`include "gpu_cfg.svh"

module gpu_line_engine
(
  input  logic              clk,
  input  logic              n_rst,
  input  logic              start_i,
  input  gpu_pkg::corners_t corners_i,
  output gpu_pkg::pixel_t   pix_o,
  output logic              valid_o,
  output logic              done_o
);

  localparam int CW = (`GPU_WIDTH_BITS > `GPU_HEIGHT_BITS) ? `GPU_WIDTH_BITS : `GPU_HEIGHT_BITS;
  localparam int EW = CW + 3;   // room for twice the error plus sign

  logic busy;
  logic [`GPU_WIDTH_BITS-1:0]  x;
  logic [`GPU_WIDTH_BITS-1:0]  x_end;
  logic [`GPU_HEIGHT_BITS-1:0] y;
  logic [`GPU_HEIGHT_BITS-1:0] y_end;
  logic signed [EW-1:0] ddx;
  logic signed [EW-1:0] ddy;
  logic signed [EW-1:0] adx;
  logic signed [EW-1:0] ndy;
  logic signed [EW-1:0] dx;
  logic signed [EW-1:0] dy;    // kept negative
  logic signed [EW-1:0] err;
  logic signed [EW-1:0] e2;
  logic sx_neg;
  logic sy_neg;

  assign ddx = EW'(corners_i.x2) - EW'(corners_i.x1);
  assign ddy = EW'(corners_i.y2) - EW'(corners_i.y1);
  assign adx = ddx[EW-1] ? -ddx : ddx;
  assign ndy = ddy[EW-1] ? ddy : -ddy;
  assign e2  = err <<< 1;

  assign pix_o.x = x;
  assign pix_o.y = y;
  assign valid_o = busy;
  assign done_o  = busy && (x == x_end) && (y == y_end);

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
      busy <= 1'b0;
    else if (start_i)
      busy <= 1'b1;
    else if (done_o)
      busy <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      x      <= corners_i.x1;
      y      <= corners_i.y1;
      x_end  <= corners_i.x2;
      y_end  <= corners_i.y2;
      dx     <= adx;
      dy     <= ndy;
      err    <= adx + ndy;
      sx_neg <= ddx[EW-1];
      sy_neg <= ddy[EW-1];
    end
    else if (busy && !done_o)
    begin
      err <= err + ((e2 >= dy) ? dy : EW'(0)) + ((e2 <= dx) ? dx : EW'(0));
      if (e2 >= dy)
        x <= sx_neg ? x - 1'b1 : x + 1'b1;
      if (e2 <= dx)
        y <= sy_neg ? y - 1'b1 : y + 1'b1;
    end
  end

endmodule

//--- source/gpu_controller.sv
module gpu_controller
(
  input  logic              clk,
  input  logic              n_rst,
  input  gpu_pkg::cmd_t     cmd_i,
  input  logic              empty_i,
  output logic              pop_o,
  output logic              line_start_o,
  output logic              fill_start_o,
  output logic              arc_start_o,
  output gpu_pkg::corners_t corners_o,
  output gpu_pkg::arc_t     arc_o,
  input  logic              line_done_i,
  input  logic              fill_done_i,
  input  logic              arc_done_i,
  output gpu_pkg::color_t   color_o,
  output logic              flush_o
);

  typedef enum logic [1:0] {IDLE, DECODE, BUSY} state_e;

  state_e state;
  state_e state_n;
  gpu_pkg::opcode_e op_q;   // draw that is running
  logic decode;
  logic draw;
  logic done;

  assign decode       = (state == DECODE);
  assign line_start_o = decode && (cmd_i.op == gpu_pkg::OP_LINE);
  assign fill_start_o = decode && (cmd_i.op == gpu_pkg::OP_FILL);
  assign arc_start_o  = decode && (cmd_i.op == gpu_pkg::OP_ARC);
  assign flush_o      = decode && (cmd_i.op == gpu_pkg::OP_FLUSH);
  assign draw         = line_start_o || fill_start_o || arc_start_o;

  // same coordinate bits, read in each view
  assign corners_o = cmd_i.coord.corners;
  assign arc_o     = cmd_i.coord.arc;

  always_comb
  begin
    case (op_q)
      gpu_pkg::OP_LINE: done = line_done_i;
      gpu_pkg::OP_FILL: done = fill_done_i;
      default:          done = arc_done_i;
    endcase
  end

  always_comb
  begin
    state_n = state;
    pop_o   = 1'b0;
    case (state)
      IDLE:
        if (!empty_i)
          state_n = DECODE;
      DECODE:
      begin
        state_n = draw ? BUSY : IDLE;
        pop_o   = !draw;   // flush and no-op retire right away
      end
      default:
        if (done)
        begin
          pop_o   = 1'b1;
          state_n = IDLE;
        end
    endcase
  end

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
      state <= IDLE;
    else
      state <= state_n;
  end

  // colour held for the pixel stage until the next draw
  always_ff @(posedge clk)
  begin
    if (draw)
    begin
      op_q    <= cmd_i.op;
      color_o <= cmd_i.color;
    end
  end

endmodule

//--- source/gpu_cmd_fifo.sv
`include "gpu_cfg.svh"

module gpu_cmd_fifo
(
  input  logic          clk,
  input  logic          n_rst,
  input  logic          push_i,
  input  gpu_pkg::cmd_t data_i,
  input  logic          pop_i,
  output gpu_pkg::cmd_t head_o,
  output logic          empty_o,
  output logic          full_o
);

  localparam int AW = $clog2(`GPU_FIFO_DEPTH);

  gpu_pkg::cmd_t mem [`GPU_FIFO_DEPTH];
  logic [AW:0] wr_ptr;   // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_push = push_i && !full_o;   // push into a full queue is lost
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr[AW-1:0]] <= data_i;
  end

endmodule

//--- source/gpu_pkg.sv
`include "gpu_cfg.svh"

package gpu_pkg;

  // anything outside these four codes is treated as a no-op
  typedef enum logic [3:0] {
    OP_LINE  = 4'b0100,
    OP_FILL  = 4'b0101,
    OP_ARC   = 4'b0111,
    OP_FLUSH = 4'b1000
  } opcode_e;

  typedef struct packed {
    logic [`GPU_WIDTH_BITS-1:0]  x1;
    logic [`GPU_HEIGHT_BITS-1:0] y1;
    logic [`GPU_WIDTH_BITS-1:0]  x2;
    logic [`GPU_HEIGHT_BITS-1:0] y2;
  } corners_t;

  typedef struct packed {
    logic [`GPU_WIDTH_BITS-1:0]  cx;
    logic [`GPU_HEIGHT_BITS-1:0] cy;
    logic [`GPU_WIDTH_BITS-1:0]  rad;
    logic [2:0]                  oct;
    logic [`GPU_HEIGHT_BITS-4:0] pad;   // fills out to the corners_t width
  } arc_t;

  typedef union packed {
    corners_t corners;
    arc_t     arc;
  } coord_u;

  typedef struct packed {
    logic [`GPU_CHANNEL_BITS-1:0] r;
    logic [`GPU_CHANNEL_BITS-1:0] g;
    logic [`GPU_CHANNEL_BITS-1:0] b;
  } color_t;

  typedef struct packed {
    opcode_e op;
    coord_u  coord;
    color_t  color;
  } cmd_t;

  typedef struct packed {
    logic [`GPU_WIDTH_BITS-1:0]  x;
    logic [`GPU_HEIGHT_BITS-1:0] y;
  } pixel_t;

  typedef struct packed {
    pixel_t pix;
    color_t color;
  } pix_wr_t;

endpackage

//--- source/gpu_cfg.svh
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// screen coordinate widths, x also sizes the arc radius
`define GPU_WIDTH_BITS 8
`define GPU_HEIGHT_BITS 8

// per colour channel
`define GPU_CHANNEL_BITS 8

// command queue entries, must stay a power of two
`define GPU_FIFO_DEPTH 8

`endif
